// File: anyIoChip.f
hdl/chipIoPkg.sv
hdl/packetizer.sv
hdl/depacketizer.sv
hdl/debugRegs.sv
hdl/chipIoTop.sv
verification/chipIo_chk.sv
verification/chipIoTb.sv

// File: hdl/chipIoPkg.sv
// chip I/O package with channel widths, packet layout, debug register map and FSM states
`default_nettype none

package chipIoPkg;

  // packet header holds valid in the MSB, then ID, then index, with the chunk below
  localparam int PKT_VALID_BITS = 1;
  localparam int PKT_ID_BITS    = 1;
  localparam int PKT_IDX_BITS   = 2;
  localparam int NUM_PKTS       = 4;  // packets per payload
  localparam int PKT_HDR_BITS   = PKT_VALID_BITS + PKT_ID_BITS + PKT_IDX_BITS;

  // store channel
  localparam int ST_ADDR_BITS    = 32;
  localparam int ST_DATA_BITS    = 32;
  localparam int ST_BYTEEN_BITS  = 4;
  localparam int ST_PAYLOAD_BITS = 72;  // 4 pad bits on top
  localparam int ST_CHUNK_BITS   = 18;
  localparam int ST_PKT_BITS     = 22;
  localparam int ST_FIFO_DEPTH   = 8;

  // load miss address channel
  localparam int LD_BLOCK_ADDR_BITS   = 28;  // 16-byte lines
  localparam int LD_ADDR_PAYLOAD_BITS = 32;
  localparam int LD_ADDR_CHUNK_BITS   = 8;
  localparam int LD_ADDR_PKT_BITS     = 12;
  localparam int LD_ADDR_FIFO_DEPTH   = 4;

  // load data channel
  localparam int LD_LINE_BITS         = 128;
  localparam int LD_DATA_PAYLOAD_BITS = 160;  // pad, block address, line
  localparam int LD_DATA_CHUNK_BITS   = 40;
  localparam int LD_DATA_PKT_BITS     = 44;

  localparam logic [PKT_ID_BITS-1:0] OUT_PKT_ID = 1'b0;  // stamped on outgoing packets
  localparam logic [PKT_ID_BITS-1:0] IN_PKT_ID  = 1'b1;  // only ID accepted on input

  // debug register bank
  localparam int REG_ADDR_BITS = 6;
  localparam int REG_DATA_BITS = 16;

  typedef enum logic [REG_ADDR_BITS-1:0] {
    REG_SCRATCH0 = 6'd0,
    REG_SCRATCH1 = 6'd1,
    REG_SCRATCH2 = 6'd2,
    REG_SCRATCH3 = 6'd3,
    REG_ST_COUNT = 6'd4,  // read-only
    REG_LD_COUNT = 6'd5,  // read-only
    REG_STATUS   = 6'd6   // bit 0 store af, bit 1 load address af
  } regAddrE;

  typedef enum logic {SER_IDLE, SER_SEND} serStateE;
  typedef enum logic {ASM_WAIT, ASM_COLLECT} asmStateE;

endpackage

`default_nettype wire

// File: hdl/chipIoTop.sv
// chip I/O boundary joining store and load-address packetizers, load-data depacketizer and debug bank
`timescale 1ns/1ns
`default_nettype none

module chipIoTop (
  input  wire                                        clk,
  input  wire                                        reset_i,

  input  wire                                        stValid_i,
  input  wire  [chipIoPkg::ST_ADDR_BITS-1:0]         stAddr_i,
  input  wire  [chipIoPkg::ST_DATA_BITS-1:0]         stData_i,
  input  wire  [chipIoPkg::ST_BYTEEN_BITS-1:0]       stByteEn_i,
  output logic                                       stAf_o,
  output logic [chipIoPkg::ST_PKT_BITS-1:0]          stPacket_o,
  input  wire                                        stPacketGrant_i,

  input  wire                                        ldAddrValid_i,
  input  wire  [chipIoPkg::LD_BLOCK_ADDR_BITS-1:0]   ldBlockAddr_i,
  output logic                                       ldAddrAf_o,
  output logic [chipIoPkg::LD_ADDR_PKT_BITS-1:0]     ldAddrPacket_o,
  input  wire                                        ldAddrPacketGrant_i,

  input  wire  [chipIoPkg::LD_DATA_PKT_BITS-1:0]     ldDataPacket_i,
  output logic                                       ldDataValid_o,
  output logic [chipIoPkg::LD_BLOCK_ADDR_BITS-1:0]   ldDataBlockAddr_o,
  output logic [chipIoPkg::LD_LINE_BITS-1:0]         ldDataLine_o,

  input  wire  [chipIoPkg::REG_ADDR_BITS-1:0]        regAddr_i,
  input  wire  [chipIoPkg::REG_DATA_BITS-1:0]        regWrData_i,
  input  wire                                        regWrEn_i,
  output logic [chipIoPkg::REG_DATA_BITS-1:0]        regRdData_o
);
  import chipIoPkg::*;

  logic [LD_DATA_PAYLOAD_BITS-1:0] ldDataPayload;  // pad, block address, line

  assign ldDataLine_o      = ldDataPayload[LD_LINE_BITS-1:0];
  assign ldDataBlockAddr_o = ldDataPayload[LD_LINE_BITS +: LD_BLOCK_ADDR_BITS];

  packetizer #(
    .PAYLOAD_BITS   (ST_PAYLOAD_BITS),
    .CHUNK_BITS     (ST_CHUNK_BITS),
    .FIFO_DEPTH     (ST_FIFO_DEPTH)
  ) stPacketizer (
    .clk            (clk),
    .reset_i        (reset_i),
    .payloadValid_i (stValid_i),
    .payload_i      ({{(ST_PAYLOAD_BITS - ST_ADDR_BITS - ST_DATA_BITS - ST_BYTEEN_BITS){1'b0}},
                      stAddr_i, stData_i, stByteEn_i}),  // pad to a whole number of chunks
    .packetGrant_i  (stPacketGrant_i),
    .pushAf_o       (stAf_o),
    .packet_o       (stPacket_o)
  );

  packetizer #(
    .PAYLOAD_BITS   (LD_ADDR_PAYLOAD_BITS),
    .CHUNK_BITS     (LD_ADDR_CHUNK_BITS),
    .FIFO_DEPTH     (LD_ADDR_FIFO_DEPTH)
  ) ldAddrPacketizer (
    .clk            (clk),
    .reset_i        (reset_i),
    .payloadValid_i (ldAddrValid_i),
    .payload_i      ({{(LD_ADDR_PAYLOAD_BITS - LD_BLOCK_ADDR_BITS){1'b0}}, ldBlockAddr_i}),
    .packetGrant_i  (ldAddrPacketGrant_i),
    .pushAf_o       (ldAddrAf_o),
    .packet_o       (ldAddrPacket_o)
  );

  depacketizer #(
    .PAYLOAD_BITS   (LD_DATA_PAYLOAD_BITS),
    .CHUNK_BITS     (LD_DATA_CHUNK_BITS)
  ) ldDataDepacketizer (
    .clk            (clk),
    .reset_i        (reset_i),
    .packet_i       (ldDataPacket_i),
    .payloadValid_o (ldDataValid_o),
    .payload_o      (ldDataPayload)
  );

  debugRegs debugBank (
    .clk            (clk),
    .reset_i        (reset_i),
    .regAddr_i      (regAddr_i),
    .regWrData_i    (regWrData_i),
    .regWrEn_i      (regWrEn_i),
    .stPush_i       (stValid_i),      // counts pushes as seen by the store FIFO
    .ldDataValid_i  (ldDataValid_o),
    .stAf_i         (stAf_o),
    .ldAddrAf_i     (ldAddrAf_o),
    .regRdData_o    (regRdData_o)
  );

endmodule

`default_nettype wire

// File: hdl/debugRegs.sv
// debug register bank with scratch registers, traffic counters and a status word
`timescale 1ns/1ns
`default_nettype none

module debugRegs (
  input  wire                                  clk,
  input  wire                                  reset_i,
  input  wire  [chipIoPkg::REG_ADDR_BITS-1:0]  regAddr_i,
  input  wire  [chipIoPkg::REG_DATA_BITS-1:0]  regWrData_i,
  input  wire                                  regWrEn_i,
  input  wire                                  stPush_i,
  input  wire                                  ldDataValid_i,
  input  wire                                  stAf_i,
  input  wire                                  ldAddrAf_i,
  output logic [chipIoPkg::REG_DATA_BITS-1:0]  regRdData_o
);
  import chipIoPkg::*;

  regAddrE                  regAddr;
  logic [REG_DATA_BITS-1:0] scratch [4];
  logic [REG_DATA_BITS-1:0] stCount;
  logic [REG_DATA_BITS-1:0] ldCount;
  logic [REG_DATA_BITS-1:0] status;
  logic                     scratchSel;

  assign regAddr    = regAddrE'(regAddr_i);
  assign scratchSel = (regAddr_i < REG_ADDR_BITS'(4));
  assign status     = {{(REG_DATA_BITS - 2){1'b0}}, ldAddrAf_i, stAf_i};

  // only scratch registers take writes
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 4; i++) begin
        scratch[i] <= '0;
      end
    end else if (regWrEn_i && scratchSel) begin
      scratch[regAddr_i[1:0]] <= regWrData_i;
    end
  end

  // free-running counters that wrap at 16 bits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      stCount <= '0;
      ldCount <= '0;
    end else begin
      if (stPush_i) begin
        stCount <= stCount + 1'b1;
      end
      if (ldDataValid_i) begin
        ldCount <= ldCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      regRdData_o <= '0;
    end else begin
      case (regAddr)
        REG_SCRATCH0,
        REG_SCRATCH1,
        REG_SCRATCH2,
        REG_SCRATCH3: regRdData_o <= scratch[regAddr_i[1:0]];
        REG_ST_COUNT: regRdData_o <= stCount;
        REG_LD_COUNT: regRdData_o <= ldCount;
        REG_STATUS:   regRdData_o <= status;
        default:      regRdData_o <= '0;  // unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/depacketizer.sv
// depacketizer that checks ID and index order and assembles four chunks into a payload
`timescale 1ns/1ns
`default_nettype none

module depacketizer #(
  parameter int PAYLOAD_BITS = 160,
  parameter int CHUNK_BITS   = 40
) (
  input  wire                                            clk,
  input  wire                                            reset_i,
  input  wire  [chipIoPkg::PKT_HDR_BITS+CHUNK_BITS-1:0]  packet_i,
  output logic                                           payloadValid_o,
  output logic [PAYLOAD_BITS-1:0]                        payload_o
);
  import chipIoPkg::*;

  localparam int PKT_BITS = PKT_HDR_BITS + CHUNK_BITS;
  localparam logic [PKT_IDX_BITS-1:0] LAST_IDX = PKT_IDX_BITS'(NUM_PKTS - 1);

  logic                    pktValid;
  logic [PKT_ID_BITS-1:0]  pktId;
  logic [PKT_IDX_BITS-1:0] pktIdx;
  logic [CHUNK_BITS-1:0]   pktChunk;
  logic                    pktTaken;
  logic                    inOrder;
  logic                    setDone;

  asmStateE                asmState;
  logic [PKT_IDX_BITS-1:0] expIdx;  // index expected next
  logic [PAYLOAD_BITS-1:0] asmBuf;

  assign pktValid = packet_i[PKT_BITS-1];
  assign pktId    = packet_i[PKT_BITS-PKT_VALID_BITS-1 -: PKT_ID_BITS];
  assign pktIdx   = packet_i[CHUNK_BITS +: PKT_IDX_BITS];
  assign pktChunk = packet_i[CHUNK_BITS-1:0];

  assign pktTaken = pktValid && (pktId == IN_PKT_ID);  // foreign IDs ignored
  assign inOrder  = (asmState == ASM_COLLECT) && (pktIdx == expIdx);
  assign setDone  = pktTaken && inOrder && (pktIdx == LAST_IDX);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      asmState       <= ASM_WAIT;
      expIdx         <= '0;
      payloadValid_o <= 1'b0;
    end else begin
      payloadValid_o <= setDone;  // single-cycle pulse
      if (pktTaken) begin
        if (pktIdx == '0) begin
          asmState <= ASM_COLLECT;  // index 0 always restarts
          expIdx   <= PKT_IDX_BITS'(1);
        end else if (setDone) begin
          asmState <= ASM_WAIT;
          expIdx   <= '0;
        end else if (inOrder) begin
          expIdx <= expIdx + 1'b1;
        end else begin
          asmState <= ASM_WAIT;  // out of order so the partial payload is dropped
          expIdx   <= '0;
        end
      end
    end
  end

  // chunks enter at the top, so index 0 ends at the bottom after four shifts
  always_ff @(posedge clk) begin
    if (pktTaken) begin
      asmBuf <= {pktChunk, asmBuf[PAYLOAD_BITS-1:CHUNK_BITS]};
    end
    if (setDone) begin
      payload_o <= {pktChunk, asmBuf[PAYLOAD_BITS-1:CHUNK_BITS]};  // held between pulses
    end
  end

endmodule

`default_nettype wire

// File: hdl/packetizer.sv
// packetizer that buffers payloads in a FIFO and sends them as four header-stamped packets
`timescale 1ns/1ns
`default_nettype none

module packetizer #(
  parameter int PAYLOAD_BITS = 72,
  parameter int CHUNK_BITS   = 18,
  parameter int FIFO_DEPTH   = 8
) (
  input  wire                                            clk,
  input  wire                                            reset_i,
  input  wire                                            payloadValid_i,
  input  wire  [PAYLOAD_BITS-1:0]                        payload_i,
  input  wire                                            packetGrant_i,
  output logic                                           pushAf_o,
  output logic [chipIoPkg::PKT_HDR_BITS+CHUNK_BITS-1:0]  packet_o
);
  import chipIoPkg::*;

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam logic [PKT_IDX_BITS-1:0] LAST_IDX = PKT_IDX_BITS'(NUM_PKTS - 1);

  logic [PAYLOAD_BITS-1:0] fifoMem [FIFO_DEPTH];
  logic [PTR_BITS-1:0]     wrPtr;
  logic [PTR_BITS-1:0]     wrPtrNext;
  logic [PTR_BITS-1:0]     rdPtr;
  logic [PTR_BITS-1:0]     rdPtrNext;
  logic [CNT_BITS-1:0]     count;
  logic                    full;
  logic                    push;
  logic                    pop;

  serStateE                serState;
  logic [PKT_IDX_BITS-1:0] pktIdx;
  logic [PAYLOAD_BITS-1:0] serBuf;  // current item shifted down one chunk per grant
  logic                    lastSent;
  logic                    loadAvail;
  logic                    loadNow;
  logic [PAYLOAD_BITS-1:0] loadData;

  assign full      = (count == CNT_BITS'(FIFO_DEPTH));
  assign push      = payloadValid_i && !full;
  assign pushAf_o  = (count >= CNT_BITS'(FIFO_DEPTH - 2));  // room for one push in flight
  assign wrPtrNext = (wrPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
  assign rdPtrNext = (rdPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;

  // head entry leaves the FIFO once its last packet is consumed
  assign lastSent = (serState == SER_SEND) && packetGrant_i && (pktIdx == LAST_IDX);
  assign pop      = lastSent;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtrNext;
      end
      if (pop) begin
        rdPtr <= rdPtrNext;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifoMem[wrPtr] <= payload_i;
    end
  end

  // next item to serialize is bypassed from the input when no FIFO entry waits
  always_comb begin
    if (serState == SER_IDLE) begin
      loadAvail = push;  // FIFO is always empty while idle
      loadData  = payload_i;
    end else begin
      loadAvail = (count > CNT_BITS'(1)) || push;  // entry behind the head
      loadData  = (count > CNT_BITS'(1)) ? fifoMem[rdPtrNext] : payload_i;
    end
  end

  assign loadNow = ((serState == SER_IDLE) || lastSent) && loadAvail;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      serState <= SER_IDLE;
      pktIdx   <= '0;
    end else begin
      case (serState)
        SER_IDLE: begin
          if (loadNow) begin
            serState <= SER_SEND;
            pktIdx   <= '0;
          end
        end
        SER_SEND: begin
          if (packetGrant_i) begin
            if (pktIdx == LAST_IDX) begin
              pktIdx <= '0;
              if (!loadNow) begin
                serState <= SER_IDLE;  // nothing queued
              end
            end else begin
              pktIdx <= pktIdx + 1'b1;
            end
          end
        end
        default: serState <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (loadNow) begin
      serBuf <= loadData;
    end else if ((serState == SER_SEND) && packetGrant_i) begin
      serBuf <= serBuf >> CHUNK_BITS;  // expose the next chunk
    end
  end

  // word holds steady while not granted and is all zero when idle
  always_comb begin
    if (serState == SER_SEND) begin
      packet_o = {{PKT_VALID_BITS{1'b1}}, OUT_PKT_ID, pktIdx, serBuf[CHUNK_BITS-1:0]};
    end else begin
      packet_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the chip I/O testbench with Verilator, runs it, and scans the log for failure
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f anyIoChip.f --top-module chipIoTb \
  -Mdir obj_dir -o chipIoSim > build.log 2>&1 \
  && ./obj_dir/chipIoSim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }

// File: verification/chipIoTb.sv
// testbench for the chip I/O boundary with LCG stimulus, reference packing and scoreboards
`timescale 1ns/1ns
`default_nettype none

module chipIoTb;
  import chipIoPkg::*;

  localparam int ST_ITEMS   = 50;
  localparam int LDA_ITEMS  = 30;
  localparam int BP_ITEMS   = 40;
  localparam int FILL_ITEMS = ST_FIFO_DEPTH + LD_ADDR_FIFO_DEPTH;
  localparam int LDD_SETS   = 40;
  localparam int TOTAL_PKTS =
    NUM_PKTS * (ST_ITEMS + LDA_ITEMS + 2 * BP_ITEMS + FILL_ITEMS + 2 * LDD_SETS);
  localparam int TIMEOUT    = 4 * TOTAL_PKTS + 2000;

  logic                          clk;
  logic                          reset_i;
  logic                          stValid_i;
  logic [ST_ADDR_BITS-1:0]       stAddr_i;
  logic [ST_DATA_BITS-1:0]       stData_i;
  logic [ST_BYTEEN_BITS-1:0]     stByteEn_i;
  logic                          stAf_o;
  logic [ST_PKT_BITS-1:0]        stPacket_o;
  logic                          stPacketGrant_i;
  logic                          ldAddrValid_i;
  logic [LD_BLOCK_ADDR_BITS-1:0] ldBlockAddr_i;
  logic                          ldAddrAf_o;
  logic [LD_ADDR_PKT_BITS-1:0]   ldAddrPacket_o;
  logic                          ldAddrPacketGrant_i;
  logic [LD_DATA_PKT_BITS-1:0]   ldDataPacket_i;
  logic                          ldDataValid_o;
  logic [LD_BLOCK_ADDR_BITS-1:0] ldDataBlockAddr_o;
  logic [LD_LINE_BITS-1:0]       ldDataLine_o;
  logic [REG_ADDR_BITS-1:0]      regAddr_i;
  logic [REG_DATA_BITS-1:0]      regWrData_i;
  logic                          regWrEn_i;
  logic [REG_DATA_BITS-1:0]      regRdData_o;

  logic [31:0]                     lcgState;
  logic [ST_PAYLOAD_BITS-1:0]      stExp [$];      // expected store payloads in push order
  logic [LD_ADDR_PAYLOAD_BITS-1:0] ldAddrExp [$];
  logic [LD_DATA_PAYLOAD_BITS-1:0] ldDataExp [$];
  logic [PKT_IDX_BITS-1:0]         stIdx;
  logic [PKT_IDX_BITS-1:0]         ldAddrIdx;
  int                              stErrors;
  int                              ldAddrErrors;
  int                              ldDataErrors;
  int                              regErrors;
  int                              stPushes;
  int                              ldDataSets;     // sets that must give a pulse
  int                              cycleCount;

  chipIoTop i_chipIoTop (.*);

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // 4 pad bits, address, data, byte enable
  function automatic logic [ST_PAYLOAD_BITS-1:0] packStore(logic [31:0] addr,
                                                          logic [31:0] data, logic [3:0] be);
    return {4'h0, addr, data, be};
  endfunction

  function automatic logic [LD_DATA_PAYLOAD_BITS-1:0] packLdData(logic [27:0] blk,
                                                                 logic [127:0] line);
    return {4'h0, blk, line};
  endfunction

  // valid, ID, index, then the chunk; index 0 carries the low chunk
  function automatic logic [ST_PKT_BITS-1:0] stPacket(logic [ST_PAYLOAD_BITS-1:0] p, int idx);
    return {1'b1, 1'b0, 2'(idx), p[idx*ST_CHUNK_BITS +: ST_CHUNK_BITS]};
  endfunction

  function automatic logic [LD_ADDR_PKT_BITS-1:0] ldAddrPacket(
    logic [LD_ADDR_PAYLOAD_BITS-1:0] p, int idx);
    return {1'b1, 1'b0, 2'(idx), p[idx*LD_ADDR_CHUNK_BITS +: LD_ADDR_CHUNK_BITS]};
  endfunction

  function automatic logic [LD_DATA_PKT_BITS-1:0] ldDataPacket(logic id, int idx,
    logic [LD_DATA_PAYLOAD_BITS-1:0] p);
    return {1'b1, id, 2'(idx), p[idx*LD_DATA_CHUNK_BITS +: LD_DATA_CHUNK_BITS]};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // scoreboards for both outgoing channels and the load-data payload
  always @(posedge clk) begin
    if (reset_i) begin
      stIdx = '0;
      ldAddrIdx = '0;
    end else begin
      if (stPacket_o[ST_PKT_BITS-1] && stPacketGrant_i) begin
        if (stExp.size() == 0) begin
          $display("store packet sent with no store pending");
          stErrors++;
        end else begin
          if (stPacket_o != stPacket(stExp[0], stIdx)) begin
            $display("Error: stPacket_o = %h, expected %h", stPacket_o,
                     stPacket(stExp[0], stIdx));
            stErrors++;
          end
          if (stIdx == 2'd3) begin
            void'(stExp.pop_front());
          end
          stIdx = stIdx + 2'd1;
        end
      end
      if (ldAddrPacket_o[LD_ADDR_PKT_BITS-1] && ldAddrPacketGrant_i) begin
        if (ldAddrExp.size() == 0) begin
          $display("load address packet sent with no address pending");
          ldAddrErrors++;
        end else begin
          if (ldAddrPacket_o != ldAddrPacket(ldAddrExp[0], ldAddrIdx)) begin
            $display("Error: ldAddrPacket_o = %h, expected %h", ldAddrPacket_o,
                     ldAddrPacket(ldAddrExp[0], ldAddrIdx));
            ldAddrErrors++;
          end
          if (ldAddrIdx == 2'd3) begin
            void'(ldAddrExp.pop_front());
          end
          ldAddrIdx = ldAddrIdx + 2'd1;
        end
      end
      if (!stPacket_o[ST_PKT_BITS-1] && stPacket_o != '0) begin
        $display("store packet word not zero while idle");
        stErrors++;
      end
      if (ldDataValid_o) begin
        if (ldDataExp.size() == 0) begin
          $display("load data payload delivered with no packet set pending");
          ldDataErrors++;
        end else begin
          if (ldDataBlockAddr_o != ldDataExp[0][LD_LINE_BITS +: LD_BLOCK_ADDR_BITS]) begin
            $display("Error: ldDataBlockAddr_o = %h, expected %h", ldDataBlockAddr_o,
                     ldDataExp[0][LD_LINE_BITS +: LD_BLOCK_ADDR_BITS]);
            ldDataErrors++;
          end
          if (ldDataLine_o != ldDataExp[0][LD_LINE_BITS-1:0]) begin
            $display("Error: ldDataLine_o = %h, expected %h", ldDataLine_o,
                     ldDataExp[0][LD_LINE_BITS-1:0]);
            ldDataErrors++;
          end
          void'(ldDataExp.pop_front());
        end
      end
    end
  end

  task automatic pushStore();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    addr = nextRand();
    data = nextRand();
    be = 4'(nextRand() >> 28);
    stValid_i  <= 1'b1;
    stAddr_i   <= addr;
    stData_i   <= data;
    stByteEn_i <= be;
    stExp.push_back(packStore(addr, data, be));
    stPushes++;
  endtask

  task automatic pushLdAddr();
    logic [LD_BLOCK_ADDR_BITS-1:0] blk;
    blk = 28'(nextRand() >> 4);
    ldAddrValid_i <= 1'b1;
    ldBlockAddr_i <= blk;
    ldAddrExp.push_back({4'h0, blk});  // zero padded above
  endtask

  // pushes only where almost-full is low; grants random or held high
  task automatic runTraffic(int nSt, int nLd, bit randGrant);
    logic [31:0] r;
    while (nSt > 0 || nLd > 0) begin
      @(posedge clk);
      r = nextRand();
      stPacketGrant_i     <= !randGrant || r[20];
      ldAddrPacketGrant_i <= !randGrant || r[21];
      if (nSt > 0 && !stAf_o && (!randGrant || r[22])) begin
        pushStore();
        nSt--;
      end else begin
        stValid_i <= 1'b0;
      end
      if (nLd > 0 && !ldAddrAf_o && (!randGrant || r[23])) begin
        pushLdAddr();
        nLd--;
      end else begin
        ldAddrValid_i <= 1'b0;
      end
    end
    @(posedge clk);
    stValid_i     <= 1'b0;
    ldAddrValid_i <= 1'b0;
  endtask

  task automatic drain();
    @(posedge clk);
    stPacketGrant_i     <= 1'b1;
    ldAddrPacketGrant_i <= 1'b1;
    while (stExp.size() != 0 || ldAddrExp.size() != 0 || ldDataExp.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic sendLdSet(logic id, int nPkts, logic [LD_DATA_PAYLOAD_BITS-1:0] p);
    for (int i = 0; i < nPkts; i++) begin
      @(posedge clk);
      ldDataPacket_i <= ldDataPacket(id, i, p);
    end
  endtask

  task automatic regWrite(logic [REG_ADDR_BITS-1:0] addr, logic [REG_DATA_BITS-1:0] data);
    @(posedge clk);
    regAddr_i   <= addr;
    regWrData_i <= data;
    regWrEn_i   <= 1'b1;
  endtask

  // address taken one edge after the write and data read one edge later
  task automatic checkReg(logic [REG_ADDR_BITS-1:0] addr, logic [REG_DATA_BITS-1:0] expVal);
    logic [1:0] afSeen;
    @(posedge clk);
    regAddr_i <= addr;
    regWrEn_i <= 1'b0;
    @(posedge clk);
    afSeen = {ldAddrAf_o, stAf_o};
    @(posedge clk);
    if (addr == REG_STATUS) begin
      expVal = {14'h0, afSeen};
    end
    if (regRdData_o != expVal) begin
      $display("Error: regRdData_o at address %h = %h, expected %h", addr, regRdData_o, expVal);
      regErrors++;
    end
  endtask

  initial begin
    logic [31:0]                     r;
    logic [LD_DATA_PAYLOAD_BITS-1:0] p;
    logic [REG_DATA_BITS-1:0]        wdata;
    lcgState = 32'd75657;
    {stErrors, ldAddrErrors, ldDataErrors, regErrors} = '0;
    stPushes = 0;
    ldDataSets = 0;
    reset_i = 1'b1;
    stValid_i = 1'b0;
    stAddr_i = '0;
    stData_i = '0;
    stByteEn_i = '0;
    stPacketGrant_i = 1'b0;
    ldAddrValid_i = 1'b0;
    ldBlockAddr_i = '0;
    ldAddrPacketGrant_i = 1'b0;
    ldDataPacket_i = '0;
    regAddr_i = '0;
    regWrData_i = '0;
    regWrEn_i = 1'b0;
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;

    runTraffic(ST_ITEMS, LDA_ITEMS, 1'b0);  // grant held high
    runTraffic(BP_ITEMS, BP_ITEMS, 1'b1);   // random back-pressure
    @(posedge clk);
    stPacketGrant_i     <= 1'b0;
    ldAddrPacketGrant_i <= 1'b0;
    while (!(stAf_o && ldAddrAf_o)) begin   // stall both channels until almost-full
      @(posedge clk);
      if (!stAf_o) begin
        pushStore();
      end else begin
        stValid_i <= 1'b0;
      end
      if (!ldAddrAf_o) begin
        pushLdAddr();
      end else begin
        ldAddrValid_i <= 1'b0;
      end
    end
    stValid_i     <= 1'b0;
    ldAddrValid_i <= 1'b0;
    checkReg(REG_STATUS, '0);
    drain();

    for (int s = 0; s < LDD_SETS; s++) begin
      r = nextRand();
      p = packLdData(28'(nextRand() >> 4), {nextRand(), nextRand(), nextRand(), nextRand()});
      if (r[17:16] == 2'd0) begin
        sendLdSet(1'b0, 4, p);  // foreign ID
      end else if (r[17:16] == 2'd1) begin
        sendLdSet(1'b1, 2, p);  // cut off then restarted
        ldDataExp.push_back(p);
        ldDataSets++;
        sendLdSet(1'b1, 4, p);
      end else begin
        ldDataExp.push_back(p);
        ldDataSets++;
        sendLdSet(1'b1, 4, p);
      end
      repeat (r[20:18]) begin
        @(posedge clk);
        ldDataPacket_i <= '0;
      end
    end
    @(posedge clk);
    ldDataPacket_i <= '0;
    drain();

    for (int i = 0; i < 4; i++) begin
      wdata = 16'(nextRand() >> 12);
      regWrite(6'(i), wdata);
      checkReg(6'(i), wdata);
    end
    regWrite(REG_ST_COUNT, 16'hFFFF);  // read-only so the write is ignored
    checkReg(REG_ST_COUNT, 16'(stPushes));
    checkReg(REG_LD_COUNT, 16'(ldDataSets));
    checkReg(6'h3F, '0);
    checkReg(REG_STATUS, '0);

    $display("errors: store %0d, load address %0d, load data %0d, debug registers %0d",
             stErrors, ldAddrErrors, ldDataErrors, regErrors);
    if (stErrors + ldAddrErrors + ldDataErrors + regErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run still busy after %0d cycles", TIMEOUT);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/chipIo_chk.sv
// bound assertions on packet hold under back-pressure, FIFO overflow and payload pulse width
`timescale 1ns/1ns
`default_nettype none

module chipIo_chk #(
  parameter int PKT_BITS = 22
) (
  input wire                clk,
  input wire                reset_i,
  input wire [PKT_BITS-1:0] packet_i,
  input wire                grant_i,
  input wire                push_i,
  input wire                full_i,
  input wire                pulse_i
);

  // a live packet waiting for grant keeps its whole word
  holdPacket: assert property (@(posedge clk) disable iff (reset_i)
    packet_i[PKT_BITS-1] && !grant_i |=> $stable(packet_i))
    else $error("packet word changed while waiting for grant");

  noOverflow: assert property (@(posedge clk) disable iff (reset_i)
    push_i |-> !full_i)
    else $error("push arrived while the FIFO was full");

  singlePulse: assert property (@(posedge clk) disable iff (reset_i)
    pulse_i |=> !pulse_i)
    else $error("payload valid pulse lasted two cycles");

endmodule

bind packetizer chipIo_chk #(.PKT_BITS(chipIoPkg::PKT_HDR_BITS + CHUNK_BITS)) packetChk (
  .clk      (clk),
  .reset_i  (reset_i),
  .packet_i (packet_o),
  .grant_i  (packetGrant_i),
  .push_i   (payloadValid_i),
  .full_i   (full),
  .pulse_i  (1'b0)
);

bind depacketizer chipIo_chk #(.PKT_BITS(1)) pulseChk (
  .clk      (clk),
  .reset_i  (reset_i),
  .packet_i (1'b0),  // no outgoing packet here
  .grant_i  (1'b1),
  .push_i   (1'b0),
  .full_i   (1'b0),
  .pulse_i  (payloadValid_o)
);

`default_nettype wire
